//--- logic/mult_pkg.sv
`default_nettype none

package mult_pkg;

    localparam int OPERAND_WIDTH = 16;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

    // One operand pair offered to the multiplier
    typedef struct packed {
        logic     valid;
        operand_t a;
        operand_t b;
    } mult_req_t;

    // Product of the pair that entered three cycles earlier
    typedef struct packed {
        logic     valid;
        product_t product;
    } mult_rsp_t;

endpackage

`default_nettype wire

//--- logic/dadda_pkg.sv
`default_nettype none

package dadda_pkg;

    localparam int PP_ROWS   = mult_pkg::OPERAND_WIDTH;
    localparam int CLA_GROUP = 4;

    // Target heights follow d(1) = 2 and d(j+1) = floor(1.5 * d(j))
    function automatic int dadda_height(int stage);
        int d;
        d = 2;
        for (int j = 1; j < stage; j++) begin
            d = (d * 3) / 2;
        end
        return d;
    endfunction

    // Number of stages is the count of target heights below the starting row count
    function automatic int dadda_stages(int rows);
        int n;
        n = 0;
        while (dadda_height(n + 1) < rows) begin
            n++;
        end
        return n;
    endfunction

    localparam int STAGE_COUNT = dadda_stages(PP_ROWS);

    typedef logic [mult_pkg::PRODUCT_WIDTH-1:0] pp_row_t;

    // Row i already sits shifted left by i inside the product width
    typedef struct packed {
        logic                  valid;
        pp_row_t [PP_ROWS-1:0] pp;
    } pp_matrix_t;

    typedef struct packed {
        logic    valid;
        pp_row_t sum_row;
        pp_row_t carry_row;
    } row_pair_t;

endpackage

`default_nettype wire

//--- logic/pp_generator.sv
`timescale 1ns/1ps
`default_nettype none

module pp_generator (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mult_pkg::mult_req_t   req,
    output dadda_pkg::pp_matrix_t mtx
);

    localparam int ROWS = dadda_pkg::PP_ROWS;

    dadda_pkg::pp_row_t [ROWS-1:0] pp_next;

    // Each row is the multiplicand gated by one multiplier bit
    always_comb begin
        for (int i = 0; i < ROWS; i++) begin
            if (req.a[i]) begin
                pp_next[i] = dadda_pkg::pp_row_t'(req.b) << i;
            end else begin
                pp_next[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        mtx.pp <= pp_next;
        if (!rst_n) begin
            mtx.valid <= 1'b0;
        end else begin
            mtx.valid <= req.valid;
        end
    end

    // An X on an operand would spread through the whole reduction tree
    a_operands_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        req.valid |-> !$isunknown({req.a, req.b})
    ) else $error("pp_generator: unknown operand bits with req.valid high");

endmodule

`default_nettype wire

//--- logic/dadda_reduction.sv
`timescale 1ns/1ps
`default_nettype none

module dadda_reduction (
    input  logic                  clk,
    input  logic                  rst_n,
    input  dadda_pkg::pp_matrix_t mtx,
    output dadda_pkg::row_pair_t  rows
);

    localparam int WIDTH  = mult_pkg::PRODUCT_WIDTH;
    localparam int OPW    = mult_pkg::OPERAND_WIDTH;
    localparam int DEPTH  = dadda_pkg::PP_ROWS;
    localparam int STAGES = dadda_pkg::STAGE_COUNT;

    localparam int INFO_HEIGHT = 0;
    localparam int INFO_FA     = 1;
    localparam int INFO_HA     = 2;

    // Replays the schedule up to level lvl and reports the height of a column there
    // or the number of full or half adders that column gets in the step from lvl
    function automatic int tree_info(int lvl, int col, int kind);
        int h [WIDTH];
        int lo;
        int hi;
        int target;
        int cin;
        int excess;
        int nf;
        int nh;
        for (int c = 0; c < WIDTH; c++) begin
            lo = (c >= OPW) ? c - OPW + 1 : 0;
            hi = (c < DEPTH) ? c : DEPTH - 1;
            h[c] = (hi >= lo) ? hi - lo + 1 : 0;
        end
        for (int l = 0; l <= lvl; l++) begin
            if (l == lvl && kind == INFO_HEIGHT) begin
                return h[col];
            end
            target = dadda_pkg::dadda_height(STAGES - l);
            cin = 0;
            for (int c = 0; c < WIDTH; c++) begin
                // Carries from the column below count against this column's target
                excess = h[c] + cin - target;
                nf = (excess > 0) ? excess / 2 : 0;
                nh = (excess > 0) ? excess % 2 : 0;
                if (l == lvl && c == col) begin
                    return (kind == INFO_FA) ? nf : nh;
                end
                h[c] = h[c] + cin - 2 * nf - nh;
                cin = nf + nh;
            end
        end
        return 0;
    endfunction

    // Column bits at each level, packed from slot 0 upward
    logic [DEPTH-1:0] lvl_bits   [0:STAGES][0:WIDTH-1];
    logic [DEPTH-1:0] carry_bits [0:STAGES-1][0:WIDTH-1];

    dadda_pkg::pp_row_t sum_next;
    dadda_pkg::pp_row_t carry_next;

    // Gather the live bits of each matrix column
    for (genvar c = 0; c < WIDTH; c++) begin : g_load
        localparam int LO = (c >= OPW) ? c - OPW + 1 : 0;
        localparam int H0 = tree_info(0, c, INFO_HEIGHT);
        for (genvar j = 0; j < DEPTH; j++) begin : g_slot
            if (j < H0) begin : g_live
                assign lvl_bits[0][c][j] = mtx.pp[LO + j][c];
            end else begin : g_empty
                assign lvl_bits[0][c][j] = 1'b0;
            end
        end
    end

    for (genvar l = 0; l < STAGES; l++) begin : g_stage
        for (genvar c = 0; c < WIDTH; c++) begin : g_col
            localparam int H    = tree_info(l, c, INFO_HEIGHT);
            localparam int NF   = tree_info(l, c, INFO_FA);
            localparam int NH   = tree_info(l, c, INFO_HA);
            localparam int KEEP = H - 2 * NF - NH;
            localparam int CIN  = (c == 0) ? 0 :
                tree_info(l, c - 1, INFO_FA) + tree_info(l, c - 1, INFO_HA);

            // Full adders take the bottom slots three at a time
            for (genvar k = 0; k < NF; k++) begin : g_fa
                logic [2:0] fa_in;
                assign fa_in = lvl_bits[l][c][3*k +: 3];
                assign lvl_bits[l+1][c][k] = ^fa_in;
                assign carry_bits[l][c][k] = (fa_in[0] & fa_in[1]) |
                                             (fa_in[0] & fa_in[2]) |
                                             (fa_in[1] & fa_in[2]);
            end

            if (NH == 1) begin : g_ha
                logic [1:0] ha_in;
                assign ha_in = lvl_bits[l][c][3*NF +: 2];
                assign lvl_bits[l+1][c][NF] = ha_in[0] ^ ha_in[1];
                assign carry_bits[l][c][NF] = ha_in[0] & ha_in[1];
            end

            // Above the adder sums come untouched bits, then carries from column c-1
            for (genvar j = NF + NH; j < DEPTH; j++) begin : g_slot
                if (j < KEEP) begin : g_pass
                    assign lvl_bits[l+1][c][j] = lvl_bits[l][c][j + 2*NF + NH];
                end else if (j < KEEP + CIN) begin : g_carry
                    assign lvl_bits[l+1][c][j] = carry_bits[l][c-1][j - KEEP];
                end else begin : g_empty
                    assign lvl_bits[l+1][c][j] = 1'b0;
                end
            end

            for (genvar k = NF + NH; k < DEPTH; k++) begin : g_no_carry
                assign carry_bits[l][c][k] = 1'b0;
            end
        end
    end

    for (genvar c = 0; c < WIDTH; c++) begin : g_out
        assign sum_next[c]   = lvl_bits[STAGES][c][0];
        assign carry_next[c] = lvl_bits[STAGES][c][1];
    end

    always_ff @(posedge clk) begin
        rows.sum_row   <= sum_next;
        rows.carry_row <= carry_next;
        if (!rst_n) begin
            rows.valid <= 1'b0;
        end else begin
            rows.valid <= mtx.valid;
        end
    end

    // A reset cycle must flush whatever the previous stage was holding
    a_reset_flush : assert property (
        @(posedge clk) !rst_n |=> !rows.valid && !mtx.valid
    ) else $error("dadda_reduction: valid still high right after reset");

endmodule

`default_nettype wire

//--- logic/cla_final_adder.sv
`timescale 1ns/1ps
`default_nettype none

module cla_final_adder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dadda_pkg::row_pair_t rows,
    output mult_pkg::mult_rsp_t  rsp
);

    localparam int WIDTH  = mult_pkg::PRODUCT_WIDTH;
    localparam int GROUP  = dadda_pkg::CLA_GROUP;
    localparam int GROUPS = WIDTH / GROUP;

    logic [WIDTH-1:0]   gen;
    logic [WIDTH-1:0]   prop;
    logic [WIDTH-1:0]   carry;
    logic [GROUPS-1:0]  grp_gen;
    logic [GROUPS-1:0]  grp_prop;
    logic [GROUPS-1:0]  grp_carry;
    mult_pkg::product_t sum;

    assign gen  = rows.sum_row & rows.carry_row;
    assign prop = rows.sum_row ^ rows.carry_row;

    always_comb begin
        logic g_acc;
        logic p_acc;
        for (int k = 0; k < GROUPS; k++) begin
            g_acc = 1'b0;
            p_acc = 1'b1;
            for (int i = 0; i < GROUP; i++) begin
                g_acc = gen[k*GROUP + i] | (prop[k*GROUP + i] & g_acc);
                p_acc = p_acc & prop[k*GROUP + i];
            end
            grp_gen[k]  = g_acc;
            grp_prop[k] = p_acc;
        end
    end

    // Carry into group k is the OR of every lower group generate
    // propagated through all groups between them
    always_comb begin
        logic term;
        logic c_acc;
        grp_carry[0] = 1'b0;
        for (int k = 1; k < GROUPS; k++) begin
            c_acc = 1'b0;
            for (int j = 0; j < k; j++) begin
                term = grp_gen[j];
                for (int m = j + 1; m < k; m++) begin
                    term = term & grp_prop[m];
                end
                c_acc = c_acc | term;
            end
            grp_carry[k] = c_acc;
        end
    end

    always_comb begin
        for (int k = 0; k < GROUPS; k++) begin
            carry[k*GROUP] = grp_carry[k];
            for (int i = 1; i < GROUP; i++) begin
                carry[k*GROUP + i] = gen[k*GROUP + i - 1] |
                                     (prop[k*GROUP + i - 1] & carry[k*GROUP + i - 1]);
            end
        end
    end

    assign sum = prop ^ carry;

    always_ff @(posedge clk) begin
        rsp.product <= sum;
        if (!rst_n) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= rows.valid;
        end
    end

    // A valid product is the plain sum of the two rows it came from
    a_valid_follows : assert property (
        @(posedge clk) rst_n |=> (rsp.valid == $past(rows.valid)) &&
            (!rsp.valid || rsp.product == $past(rows.sum_row + rows.carry_row))
    ) else $error("cla_final_adder: rsp does not follow rows");

endmodule

`default_nettype wire

//--- logic/dadda_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

// Three register stages: partial products, Dadda reduction, final CLA
module dadda_multiplier (
    input  logic                clk,
    input  logic                rst_n,
    input  mult_pkg::mult_req_t req,
    output mult_pkg::mult_rsp_t rsp
);

    dadda_pkg::pp_matrix_t mtx;
    dadda_pkg::row_pair_t  rows;

    pp_generator pp_gen0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .mtx   (mtx)
    );

    dadda_reduction reduction0 (
        .clk   (clk),
        .rst_n (rst_n),
        .mtx   (mtx),
        .rows  (rows)
    );

    cla_final_adder final_adder0 (
        .clk   (clk),
        .rst_n (rst_n),
        .rows  (rows),
        .rsp   (rsp)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    input  logic soft_rst,
    output logic clk,
    output logic rst_n
);

    localparam int RESET_CYCLES = 2;

    logic por_n;

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        por_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        por_n = 1'b1;
    end

    // The testbench can pull reset low again in the middle of a run
    assign rst_n = por_n & ~soft_rst;

endmodule

`default_nettype wire

//--- sim/dadda_multiplier_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dadda_multiplier_tb;

    localparam int NUM_ROWS     = 17;
    localparam int RANDOM_PAIRS = 200;
    localparam int LATENCY      = 3;
    localparam int RESET_LIMIT  = 20;
    localparam int DRAIN_LIMIT  = 20;

    typedef struct packed {
        logic               valid;
        mult_pkg::operand_t a;
        mult_pkg::operand_t b;
        mult_pkg::product_t product;
    } vector_t;

    typedef struct packed {
        mult_pkg::product_t product;
        logic [31:0]        due;
    } expect_t;

    logic                clk;
    logic                rst_n;
    logic                soft_rst;
    logic                mon_en;
    mult_pkg::mult_req_t req;
    mult_pkg::mult_rsp_t rsp;

    logic [31:0]   cyc = '0;
    logic [15:0]   lfsr_state = 16'd26275;
    vector_t       tbl [NUM_ROWS];
    expect_t       exp_q [$];
    int            mismatch_count = 0;
    int            fail_count = 0;
    int            sent_count = 0;
    int            dropped_count = 0;
    int            rcvd_count = 0;

    tb_clock clock0 (
        .soft_rst (soft_rst),
        .clk      (clk),
        .rst_n    (rst_n)
    );

    dadda_multiplier dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t ns: %s got 0x%08h, expected 0x%08h",
                     $time, name, got, expected);
            mismatch_count++;
        end
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic draw_operand(output mult_pkg::operand_t value);
        value = '0;
        for (int i = 0; i < mult_pkg::OPERAND_WIDTH; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[mult_pkg::OPERAND_WIDTH-2:0], lfsr_state[0]};
        end
    endtask

    // Rows with valid low are gaps and expect no response
    task automatic load_table();
        tbl[0]  = '{1'b1, 16'h0000, 16'h1234, 32'h0000_0000};
        tbl[1]  = '{1'b1, 16'hBEEF, 16'h0000, 32'h0000_0000};
        tbl[2]  = '{1'b1, 16'h0001, 16'hABCD, 32'h0000_ABCD};
        tbl[3]  = '{1'b1, 16'hFFFF, 16'h0001, 32'h0000_FFFF};
        tbl[4]  = '{1'b1, 16'hFFFF, 16'hFFFF, 32'hFFFE_0001};
        tbl[5]  = '{1'b0, 16'hDEAD, 16'hBEEF, 32'h0000_0000};
        tbl[6]  = '{1'b1, 16'h8000, 16'h8000, 32'h4000_0000};
        tbl[7]  = '{1'b1, 16'h0100, 16'h0010, 32'h0000_1000};
        tbl[8]  = '{1'b1, 16'h0004, 16'h0200, 32'h0000_0800};
        tbl[9]  = '{1'b0, 16'h1111, 16'h2222, 32'h0000_0000};
        tbl[10] = '{1'b0, 16'h3333, 16'h4444, 32'h0000_0000};
        tbl[11] = '{1'b1, 16'hAAAA, 16'h5555, 32'h38E3_1C72};
        tbl[12] = '{1'b1, 16'h5555, 16'h5555, 32'h1C71_8E39};
        tbl[13] = '{1'b1, 16'hAAAA, 16'hAAAA, 32'h71C6_38E4};
        tbl[14] = '{1'b1, 16'h8000, 16'hFFFF, 32'h7FFF_8000};
        tbl[15] = '{1'b1, 16'h00FF, 16'h00FF, 32'h0000_FE01};
        tbl[16] = '{1'b1, 16'hFFFF, 16'h0002, 32'h0001_FFFE};
    endtask

    // A request driven in cycle n shows up on rsp during cycle n + 3
    task automatic apply_pair(input logic valid, input mult_pkg::operand_t a,
                              input mult_pkg::operand_t b,
                              input mult_pkg::product_t product);
        expect_t entry;
        @(posedge clk);
        #1;
        req.valid = valid;
        req.a = a;
        req.b = b;
        if (valid) begin
            entry.product = product;
            entry.due = cyc + LATENCY;
            exp_q.push_back(entry);
            sent_count++;
        end
    endtask

    task automatic apply_random(input int count);
        mult_pkg::operand_t a;
        mult_pkg::operand_t b;
        for (int i = 0; i < count; i++) begin
            draw_operand(a);
            draw_operand(b);
            apply_pair(1'b1, a, b, mult_pkg::product_t'(a) * mult_pkg::product_t'(b));
        end
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        apply_pair(1'b0, '0, '0, '0);
        while (exp_q.size() != 0 && waited < limit) begin
            apply_pair(1'b0, '0, '0, '0);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout at %0t ns: %0d responses never arrived", $time, exp_q.size());
            fail_count++;
        end
    endtask

    always @(negedge clk) begin : monitor
        expect_t head;
        if (mon_en && rsp.valid === 1'b1) begin
            rcvd_count++;
            if (exp_q.size() == 0) begin
                $display("error at %0t ns: response 0x%08h came with no request outstanding",
                         $time, rsp.product);
                fail_count++;
            end else begin
                head = exp_q.pop_front();
                compare("rsp.product", rsp.product, head.product);
                compare("response cycle", cyc, head.due);
            end
        end else if (mon_en && rsp.valid !== 1'b0) begin
            $display("error at %0t ns: rsp.valid is unknown", $time);
            fail_count++;
        end
    end

    initial begin : main
        int waited;
        req = '0;
        soft_rst = 1'b0;
        mon_en = 1'b0;
        load_table();

        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout at %0t ns: reset was never released", $time);
            fail_count++;
        end
        #1;
        compare("rsp.valid", {31'b0, rsp.valid}, 32'h0);
        mon_en = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_pair(tbl[i].valid, tbl[i].a, tbl[i].b, tbl[i].product);
        end
        apply_random(RANDOM_PAIRS);
        wait_drain(DRAIN_LIMIT);

        // Two pairs are still inside the pipeline when reset hits
        apply_random(2);
        @(posedge clk);
        #1;
        req.valid = 1'b0;
        soft_rst = 1'b1;
        dropped_count += exp_q.size();
        exp_q.delete();
        @(posedge clk);
        #1;
        soft_rst = 1'b0;
        compare("rsp.valid", {31'b0, rsp.valid}, 32'h0);
        for (int i = 0; i < 6; i++) begin
            apply_pair(1'b0, '0, '0, '0);
        end

        apply_random(8);
        wait_drain(DRAIN_LIMIT);
        compare("response count", rcvd_count, sent_count - dropped_count);

        $display("summary: %0d mismatches, %0d other failures, %0d responses for %0d requests",
                 mismatch_count, fail_count, rcvd_count, sent_count - dropped_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
logic/mult_pkg.sv
logic/dadda_pkg.sv
logic/pp_generator.sv
logic/dadda_reduction.sv
logic/cla_final_adder.sv
logic/dadda_multiplier.sv
sim/tb_clock.sv
sim/dadda_multiplier_tb.sv

//--- Makefile
# Verilator flow for the pipelined Dadda multiplier

VERILATOR ?= verilator
TOP       ?= dadda_multiplier_tb
RTL_TOP   ?= dadda_multiplier
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
PASS_TEXT ?= TEST PASS
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
